//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = packet_buffer_tb
FILELIST = all.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log for a pass"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- all.f
src/buffer_geom_pkg.sv
src/packet_pkg.sv
src/sram.sv
src/ecc_encoder.sv
src/free_page_queue.sv
src/page_link_table.sv
src/sram_interface.sv
src/packet_buffer_top.sv
sim/packet_buffer_assert.sv
sim/packet_buffer_tb.sv

//--- sim/packet_buffer_assert.sv
module packet_buffer_assert #(
    parameter int PAGE_ADDR_W = buffer_geom_pkg::PAGE_ADDR_W_DEF
) (
    input logic                   clk,
    input logic                   rst_n,
    input logic [4:0]             time_stamp,
    input logic                   join_request_enable,
    input logic [5:0]             join_request_time_stamp,
    input logic                   rd_page_down,
    input logic                   rd_xfer_data_vld,
    input logic [PAGE_ADDR_W-1:0] free_space
);

    timeunit 1ns;
    timeprecision 1ps;

    ////////////////////////////////////////////////////////////
    // Reset and join
    ////////////////////////////////////////////////////////////

    reset_values: assert property (@(posedge clk)
        !rst_n |=> (!join_request_enable && !rd_xfer_data_vld &&
                    join_request_time_stamp == packet_pkg::TS_IDLE && free_space == '1))
        else $error("Outputs not at their reset values");

    join_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        join_request_enable |=> !join_request_enable)      // Single-cycle pulse
        else $error("Join request longer than one cycle");

    join_stamp: assert property (@(posedge clk) disable iff (!rst_n)
        join_request_enable |-> join_request_time_stamp == {1'b0, 5'($past(time_stamp) + 1'b1)})
        else $error("Join timestamp is not the header stamp plus one");

    ////////////////////////////////////////////////////////////
    // Read burst and free count
    ////////////////////////////////////////////////////////////

    read_burst: assert property (@(posedge clk) disable iff (!rst_n)
        rd_page_down |=> rd_xfer_data_vld [*8] ##1 !rd_xfer_data_vld)
        else $error("Read burst is not eight valid cycles");

    free_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !join_request_enable && !rd_page_down |=> free_space == $past(free_space))
        else $error("Free count moved without a join or page-down");

    free_up: assert property (@(posedge clk) disable iff (!rst_n)
        !join_request_enable && rd_page_down |=> free_space == $past(free_space) + 1'b1)
        else $error("Free count did not rise by one on page-down");

    free_down: assert property (@(posedge clk) disable iff (!rst_n)
        join_request_enable && !rd_page_down |=> free_space < $past(free_space))
        else $error("Free count did not drop on a join");

endmodule

bind packet_buffer_top packet_buffer_assert #(
    .PAGE_ADDR_W(PAGE_ADDR_W)
) packet_buffer_assert_i (.*);

//--- sim/packet_buffer_tb.sv
module packet_buffer_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PW = 6;                                  // Small buffer, 64 pages
    localparam int GA_W = buffer_geom_pkg::SRAM_IDX_W + PW;
    localparam int NPKT = 6;
    localparam logic [buffer_geom_pkg::SRAM_IDX_W-1:0] SRAM_IDX = 5'h13;

    logic                  clk;
    logic                  rst_n;
    logic [4:0]            time_stamp;
    logic [4:0]            sram_idx;
    logic                  wr_xfer_data_vld;
    logic [15:0]           wr_xfer_data;
    logic                  wr_end_of_packet;
    logic                  concatenate_enable;
    logic [PW-1:0]         concatenate_head;
    logic [GA_W-1:0]       concatenate_tail;
    logic                  rd_page_down;
    logic [PW-1:0]         rd_page;
    logic [3:0]            join_request_dest_port;
    logic [2:0]            join_request_prior;
    logic [GA_W-1:0]       join_request_head;
    logic [GA_W-1:0]       join_request_tail;
    logic                  join_request_enable;
    logic [5:0]            join_request_time_stamp;
    logic                  rd_xfer_data_vld;
    logic [15:0]           rd_xfer_data;
    logic [GA_W-1:0]       rd_next_page;
    logic [7:0]            rd_ecc_code;
    logic [PW-1:0]         free_space;

    int          errors;
    int          timeouts;
    int          total_pages;
    int          pages_read;
    int          free_q [$];                                // Model of the free-page queue
    int          exp_port [$];
    int          exp_prior [$];
    int          exp_head [$];
    int          exp_tail [$];
    int          exp_ts [$];
    time         exp_join_at [$];                           // Sample time of each join pulse
    logic [15:0] pkt_words [NPKT][32];                      // Written words per packet
    int          pkt_nwords [NPKT];
    int          pkt_pages [NPKT][4];
    int          pkt_npages [NPKT];

    packet_buffer_top #(
        .PAGE_ADDR_W(PW)
    ) packet_buffer_top_i (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        #1;
        time_stamp <= time_stamp + 1'b1; // Free-running stamp source
    end

    initial begin
        #100us;
        $display("Simulation time limit reached before the test finished");
        $display("TESTBENCH FAILED");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %0h got %0h", $time, name, exp_v, act_v);
        end
    endtask

    // Position code over the 128 page bits, zero past the last written word
    function automatic logic [7:0] page_code(input int k, input int pi);
        logic [15:0] w;
        logic        b;
        logic [7:0]  c;
        int          idx;
        c = '0;
        for (int p = 0; p < 128; p++) begin
            idx = pi * 8 + p / 16;
            w = (idx < pkt_nwords[k]) ? pkt_words[k][idx] : 16'h0;
            b = w[p % 16];
            for (int j = 0; j < 7; j++) begin
                if ((p >> j) & 1) c[j] = c[j] ^ b;
            end
            c[7] = c[7] ^ b; // Overall parity
        end
        return c;
    endfunction

    task automatic write_packet(input int k);
        int          npages;
        int          nwords;
        logic [15:0] hdr;
        npages = 1 + $urandom % 4;
        nwords = (npages - 1) * 8 + 1 + $urandom % 8;      // Last page may be short
        hdr = 16'($urandom);
        hdr[packet_pkg::HDR_LEN_LSB +: 6] = 6'(npages - 1);
        pkt_npages[k] = npages;
        pkt_nwords[k] = nwords;
        for (int p = 0; p < npages; p++) begin
            pkt_pages[k][p] = free_q.pop_front();
        end
        for (int i = 0; i < nwords; i++) begin
            pkt_words[k][i] = (i == 0) ? hdr : 16'($urandom);
        end
        exp_port.push_back(int'(hdr[packet_pkg::HDR_PORT_LSB +: 4]));
        exp_prior.push_back(int'(hdr[packet_pkg::HDR_PRIOR_LSB +: 3]));
        exp_head.push_back(int'({SRAM_IDX, PW'(pkt_pages[k][0])}));
        exp_tail.push_back(int'({SRAM_IDX, PW'(pkt_pages[k][npages-1])}));
        total_pages += npages;
        for (int i = 0; i < nwords; i++) begin
            @(posedge clk);
            #1;
            wr_xfer_data_vld = 1'b1;
            wr_xfer_data     = pkt_words[k][i];
            wr_end_of_packet = (i == nwords - 1);
            if (i == 0) begin
                @(negedge clk);
                exp_ts.push_back(int'(5'(time_stamp + 1'b1))); // Stamp seen at the header
                exp_join_at.push_back($time + 10);             // Next cycle's sample point
            end
        end
        @(posedge clk);
        #1;
        wr_xfer_data_vld = 1'b0;
        wr_end_of_packet = 1'b0;
        repeat (2) @(posedge clk);                          // Gap between packets
    endtask

    task automatic read_page(input int k, input int pi);
        int pg;
        int cnt;
        pg = pkt_pages[k][pi];
        @(posedge clk);
        #1;
        rd_page      = PW'(pg);
        rd_page_down = 1'b1;
        @(posedge clk);
        #1;
        rd_page_down = 1'b0;                                // rd_page held through the burst
        cnt = 0;
        @(negedge clk);
        while (!rd_xfer_data_vld && cnt < 20) begin
            @(negedge clk);
            cnt++;
        end
        if (!rd_xfer_data_vld) begin
            errors++;
            timeouts++;
            $display("Timed out waiting for read data of page %0d", pg);
        end else begin
            if (pi < pkt_npages[k] - 1) begin
                check_value("rd_next_page", {SRAM_IDX, PW'(pkt_pages[k][pi+1])}, rd_next_page);
            end else if (k == 0) begin
                check_value("rd_next_page", {SRAM_IDX, PW'(pkt_pages[1][0])}, rd_next_page);
            end
            check_value("rd_ecc_code", page_code(k, pi), rd_ecc_code);
            for (int w = 0; w < 8; w++) begin
                if (!rd_xfer_data_vld) begin
                    errors++;
                    $display("Read valid dropped inside the burst of page %0d at %0t", pg, $time);
                end else if (pi * 8 + w < pkt_nwords[k]) begin
                    check_value("rd_xfer_data", pkt_words[k][pi*8+w], rd_xfer_data);
                end
                if (w < 7) @(negedge clk);
            end
        end
        pages_read++;
    endtask

    ////////////////////////////////////////////////////////////
    // Join request monitor
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin : join_monitor
        int tail_v;
        if (rst_n && join_request_enable) begin
            if (exp_head.size() == 0) begin
                errors++;
                $display("Join request without a packet header at %0t", $time);
            end else begin
                if ($time != exp_join_at.pop_front()) begin
                    errors++;
                    $display("Join request at %0t is not in the cycle after its header", $time);
                end
                check_value("join_request_dest_port", exp_port.pop_front(), join_request_dest_port);
                check_value("join_request_prior", exp_prior.pop_front(), join_request_prior);
                check_value("join_request_head", exp_head.pop_front(), join_request_head);
                check_value("join_request_time_stamp", exp_ts.pop_front(), join_request_time_stamp);
                tail_v = exp_tail.pop_front();
                @(negedge clk);                             // Tail lands one cycle later
                check_value("join_request_tail", tail_v, join_request_tail);
            end
        end
    end

    initial begin
        void'($urandom(92));
        errors = 0;
        timeouts = 0;
        total_pages = 0;
        pages_read = 0;
        clk = 1'b0;
        rst_n = 1'b0;
        time_stamp = '0;
        sram_idx = SRAM_IDX;
        wr_xfer_data_vld = 1'b0;
        wr_xfer_data = '0;
        wr_end_of_packet = 1'b0;
        concatenate_enable = 1'b0;
        concatenate_head = '0;
        concatenate_tail = '0;
        rd_page_down = 1'b0;
        rd_page = '0;
        for (int i = 0; i < 64; i++) free_q.push_back(i);  // Fill order after reset
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (70) @(posedge clk);                         // Queue fills one page per cycle
        for (int k = 0; k < NPKT; k++) write_packet(k);
        @(posedge clk);
        #1;
        concatenate_enable = 1'b1;                          // Packet 0 tail links to packet 1
        concatenate_head   = PW'(pkt_pages[0][pkt_npages[0]-1]);
        concatenate_tail   = {SRAM_IDX, PW'(pkt_pages[1][0])};
        @(posedge clk);
        #1;
        concatenate_enable = 1'b0;
        repeat (40) @(posedge clk);                         // Stamp wraps after 32 cycles
        @(negedge clk);
        if (exp_head.size() != 0) begin
            errors++;
            $display("%0d join requests never arrived", exp_head.size());
        end
        check_value("join_request_time_stamp", 32, join_request_time_stamp);
        check_value("free_space", 63 - total_pages, free_space);
        for (int k = 0; k < NPKT; k++) begin
            for (int pi = 0; pi < pkt_npages[k]; pi++) read_page(k, pi);
        end
        repeat (3) @(negedge clk);
        check_value("free_space", 63 - total_pages + pages_read, free_space);
        $display("Errors: %0d, of which timeouts: %0d", errors, timeouts);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- src/buffer_geom_pkg.sv
package buffer_geom_pkg;

    //////////////////////////////////////////////////////////////
    // Buffer geometry
    //////////////////////////////////////////////////////////////

    localparam int PAGE_ADDR_W_DEF = 11; // 2048 pages per bank
    localparam int WORDS_PER_PAGE  = 8;
    localparam int WORD_IDX_W      = 3;  // Word index inside a page
    localparam int WORD_W          = 16;
    localparam int CODE_W          = 8;  // Check code per page
    localparam int SRAM_IDX_W      = 5;  // Bank index, upper part of a global page address

endpackage

//--- src/ecc_encoder.sv
module ecc_encoder (
    input  logic [buffer_geom_pkg::WORD_W-1:0] word_0,
    input  logic [buffer_geom_pkg::WORD_W-1:0] word_1,
    input  logic [buffer_geom_pkg::WORD_W-1:0] word_2,
    input  logic [buffer_geom_pkg::WORD_W-1:0] word_3,
    input  logic [buffer_geom_pkg::WORD_W-1:0] word_4,
    input  logic [buffer_geom_pkg::WORD_W-1:0] word_5,
    input  logic [buffer_geom_pkg::WORD_W-1:0] word_6,
    input  logic [buffer_geom_pkg::WORD_W-1:0] word_7,
    output logic [buffer_geom_pkg::CODE_W-1:0] code
);

    localparam int PAGE_BITS =
        buffer_geom_pkg::WORDS_PER_PAGE * buffer_geom_pkg::WORD_W;

    logic [PAGE_BITS-1:0] page_bits;

    // Bit p = 16*word + bit
    assign page_bits = {word_7, word_6, word_5, word_4, word_3, word_2, word_1, word_0};

    always_comb begin
        code = '0;
        for (int p = 0; p < PAGE_BITS; p++) begin
            // Position bits, one per bit of the index p
            for (int j = 0; j < buffer_geom_pkg::CODE_W - 1; j++) begin
                if (p[j]) begin
                    code[j] = code[j] ^ page_bits[p];
                end
            end
            code[buffer_geom_pkg::CODE_W-1] = code[buffer_geom_pkg::CODE_W-1] ^ page_bits[p]; // Overall parity
        end
    end

endmodule

//--- src/free_page_queue.sv
module free_page_queue #(
    parameter int PAGE_ADDR_W = buffer_geom_pkg::PAGE_ADDR_W_DEF
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   pop,
    input  logic [PAGE_ADDR_W-1:0] peek_offset,
    output logic [PAGE_ADDR_W-1:0] head_page,
    input  logic                   recycle_vld,
    input  logic [PAGE_ADDR_W-1:0] recycle_page
);

    localparam int DEPTH = 2 ** PAGE_ADDR_W;

    logic [PAGE_ADDR_W-1:0] mem [DEPTH];
    logic [PAGE_ADDR_W-1:0] head_ptr;
    logic [PAGE_ADDR_W-1:0] tail_ptr;
    logic [PAGE_ADDR_W:0]   fill_cnt;  // Pages streamed in since reset
    logic                   fill_done;
    logic                   push;
    logic [PAGE_ADDR_W-1:0] push_page;
    logic [PAGE_ADDR_W-1:0] rd_addr;

    assign fill_done = (fill_cnt == (PAGE_ADDR_W + 1)'(DEPTH));
    assign push      = recycle_vld || !fill_done;                                // Recycles first
    assign push_page = recycle_vld ? recycle_page : fill_cnt[PAGE_ADDR_W-1:0];

    // Look past a pop in the same cycle, plus the tail peek on a header
    assign rd_addr = head_ptr + PAGE_ADDR_W'(pop) + peek_offset;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            fill_cnt <= '0;
        end else begin
            if (pop) begin
                head_ptr <= head_ptr + 1'b1;
            end
            if (push) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (!recycle_vld && !fill_done) begin
                fill_cnt <= fill_cnt + 1'b1; // Initial fill stalls on a recycle
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[tail_ptr] <= push_page;
        end
    end

    always_ff @(posedge clk) begin
        head_page <= mem[rd_addr]; // Next free page, or predicted tail after a header
    end

endmodule

//--- src/packet_buffer_top.sv
module packet_buffer_top #(
    parameter int PAGE_ADDR_W = buffer_geom_pkg::PAGE_ADDR_W_DEF,
    localparam int GA_W = buffer_geom_pkg::SRAM_IDX_W + PAGE_ADDR_W
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic [packet_pkg::TS_W-1:0]           time_stamp,
    input  logic [buffer_geom_pkg::SRAM_IDX_W-1:0] sram_idx,
    input  logic                                  wr_xfer_data_vld,
    input  logic [buffer_geom_pkg::WORD_W-1:0]    wr_xfer_data,
    input  logic                                  wr_end_of_packet,
    input  logic                                  concatenate_enable,
    input  logic [PAGE_ADDR_W-1:0]                concatenate_head,
    input  logic [GA_W-1:0]                       concatenate_tail,
    input  logic                                  rd_page_down,
    input  logic [PAGE_ADDR_W-1:0]                rd_page,
    output logic [packet_pkg::PORT_W-1:0]         join_request_dest_port,
    output logic [packet_pkg::PRIOR_W-1:0]        join_request_prior,
    output logic [GA_W-1:0]                       join_request_head,
    output logic [GA_W-1:0]                       join_request_tail,
    output logic                                  join_request_enable,
    output logic [packet_pkg::TS_W:0]             join_request_time_stamp,
    output logic                                  rd_xfer_data_vld,
    output logic [buffer_geom_pkg::WORD_W-1:0]    rd_xfer_data,
    output logic [GA_W-1:0]                       rd_next_page,
    output logic [buffer_geom_pkg::CODE_W-1:0]    rd_ecc_code,
    output logic [PAGE_ADDR_W-1:0]                free_space
);

    // Free queue handshake
    logic                   pop;
    logic [PAGE_ADDR_W-1:0] peek_offset;
    logic [PAGE_ADDR_W-1:0] head_page;
    logic                   recycle_vld;
    logic [PAGE_ADDR_W-1:0] recycle_page;

    // Link table access
    logic                   link_wr_vld;
    logic [PAGE_ADDR_W-1:0] link_page;
    logic [GA_W-1:0]        link_next;
    logic [PAGE_ADDR_W-1:0] link_rd_page;
    logic [GA_W-1:0]        link_rd_next;

    sram_interface #(
        .PAGE_ADDR_W(PAGE_ADDR_W)
    ) sram_interface_i (.*);

    free_page_queue #(
        .PAGE_ADDR_W(PAGE_ADDR_W)
    ) free_page_queue_i (.*);

    page_link_table #(
        .PAGE_ADDR_W(PAGE_ADDR_W)
    ) page_link_table_i (.*);

endmodule

//--- src/packet_pkg.sv
package packet_pkg;

    //////////////////////////////////////////////////////////////
    // Header word layout
    //////////////////////////////////////////////////////////////

    localparam int HDR_PORT_LSB  = 0;
    localparam int HDR_PRIOR_LSB = 4;
    localparam int HDR_LEN_LSB   = 10;

    localparam int PORT_W  = 4; // Destination port
    localparam int PRIOR_W = 3; // Priority
    localparam int LEN_W   = 6; // Length in pages minus one

    //////////////////////////////////////////////////////////////
    // Write FSM and join timestamp
    //////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        WR_IDLE,        // Waiting for a header
        WR_FIRST_PAGE,  // Header page being filled
        WR_LATER_PAGES  // Second page onwards
    } wr_state_e;

    localparam int TS_W = 5;
    localparam logic [TS_W:0] TS_IDLE = 6'd32; // Bit 5 set, never a real stamp

endpackage

//--- src/page_link_table.sv
module page_link_table #(
    parameter int PAGE_ADDR_W = buffer_geom_pkg::PAGE_ADDR_W_DEF,
    localparam int GA_W = buffer_geom_pkg::SRAM_IDX_W + PAGE_ADDR_W
) (
    input  logic                   clk,
    input  logic                   link_wr_vld,
    input  logic [PAGE_ADDR_W-1:0] link_page,
    input  logic [GA_W-1:0]        link_next,
    input  logic                   concatenate_enable,
    input  logic [PAGE_ADDR_W-1:0] concatenate_head,
    input  logic [GA_W-1:0]        concatenate_tail,
    input  logic [PAGE_ADDR_W-1:0] link_rd_page,
    output logic [GA_W-1:0]        link_rd_next
);

    logic [GA_W-1:0] mem [2 ** PAGE_ADDR_W]; // Global next-page address per page

    always_ff @(posedge clk) begin
        if (concatenate_enable) begin
            mem[concatenate_head] <= concatenate_tail; // Packet join beats chaining
        end else if (link_wr_vld) begin
            mem[link_page] <= link_next;               // Chain to the next page
        end
    end

    always_ff @(posedge clk) begin
        link_rd_next <= mem[link_rd_page]; // One cycle latency
    end

endmodule

//--- src/sram.sv
module sram #(
    parameter int PAGE_ADDR_W = buffer_geom_pkg::PAGE_ADDR_W_DEF
) (
    input  logic                                               clk,
    input  logic                                               wr_en,
    input  logic [PAGE_ADDR_W+buffer_geom_pkg::WORD_IDX_W-1:0] wr_addr,
    input  logic [buffer_geom_pkg::WORD_W-1:0]                 din,
    input  logic                                               rd_en,
    input  logic [PAGE_ADDR_W+buffer_geom_pkg::WORD_IDX_W-1:0] rd_addr,
    output logic [buffer_geom_pkg::WORD_W-1:0]                 dout
);

    localparam int DEPTH = (2 ** PAGE_ADDR_W) * buffer_geom_pkg::WORDS_PER_PAGE;

    logic [buffer_geom_pkg::WORD_W-1:0] mem [DEPTH]; // One word per {page, index}

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= din;
        end
    end

    // Registered read, held while idle to save power
    always_ff @(posedge clk) begin
        if (rd_en) begin
            dout <= mem[rd_addr];
        end
    end

endmodule

//--- src/sram_interface.sv
module sram_interface #(
    parameter int PAGE_ADDR_W = buffer_geom_pkg::PAGE_ADDR_W_DEF,
    localparam int GA_W = buffer_geom_pkg::SRAM_IDX_W + PAGE_ADDR_W
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic [packet_pkg::TS_W-1:0]           time_stamp,
    input  logic [buffer_geom_pkg::SRAM_IDX_W-1:0] sram_idx,
    input  logic                                  wr_xfer_data_vld,
    input  logic [buffer_geom_pkg::WORD_W-1:0]    wr_xfer_data,
    input  logic                                  wr_end_of_packet,
    input  logic                                  rd_page_down,
    input  logic [PAGE_ADDR_W-1:0]                rd_page,
    output logic [packet_pkg::PORT_W-1:0]         join_request_dest_port,
    output logic [packet_pkg::PRIOR_W-1:0]        join_request_prior,
    output logic [GA_W-1:0]                       join_request_head,
    output logic [GA_W-1:0]                       join_request_tail,
    output logic                                  join_request_enable,
    output logic [packet_pkg::TS_W:0]             join_request_time_stamp,
    output logic                                  rd_xfer_data_vld,
    output logic [buffer_geom_pkg::WORD_W-1:0]    rd_xfer_data,
    output logic [GA_W-1:0]                       rd_next_page,
    output logic [buffer_geom_pkg::CODE_W-1:0]    rd_ecc_code,
    output logic [PAGE_ADDR_W-1:0]                free_space,
    output logic                                  pop,
    output logic [PAGE_ADDR_W-1:0]                peek_offset,
    input  logic [PAGE_ADDR_W-1:0]                head_page,
    output logic                                  recycle_vld,
    output logic [PAGE_ADDR_W-1:0]                recycle_page,
    output logic                                  link_wr_vld,
    output logic [PAGE_ADDR_W-1:0]                link_page,
    output logic [GA_W-1:0]                       link_next,
    output logic [PAGE_ADDR_W-1:0]                link_rd_page,
    input  logic [GA_W-1:0]                       link_rd_next
);

    localparam int IDX_W = buffer_geom_pkg::WORD_IDX_W;
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(buffer_geom_pkg::WORDS_PER_PAGE - 1);
    localparam logic [3:0] RD_IDLE = 4'(buffer_geom_pkg::WORDS_PER_PAGE);

    packet_pkg::wr_state_e wr_state;
    logic [IDX_W-1:0]                   wr_batch;      // Word index in the current page
    logic [PAGE_ADDR_W-1:0]             page_reg;      // Page taken at word 0
    logic [PAGE_ADDR_W-1:0]             cur_page;
    logic [PAGE_ADDR_W-1:0]             tail_page;
    logic                               hdr_accept;
    logic                               page_end;
    logic [buffer_geom_pkg::WORD_W-1:0] stage [buffer_geom_pkg::WORDS_PER_PAGE];
    logic [buffer_geom_pkg::CODE_W-1:0] code;
    logic [buffer_geom_pkg::CODE_W-1:0] code_mem [2 ** PAGE_ADDR_W];
    logic                               code_wr_pend;
    logic [PAGE_ADDR_W-1:0]             code_wr_page;
    logic [packet_pkg::TS_W-1:0]        ts_next;
    logic [packet_pkg::LEN_W:0]         packet_pages;
    logic [PAGE_ADDR_W-1:0]             join_pages;
    logic [3:0]                         rd_batch;      // Idles at 8
    logic [IDX_W-1:0]                   rd_word;

    //////////////////////////////////////////////////////////////
    // Write side
    //////////////////////////////////////////////////////////////

    assign hdr_accept = (wr_state == packet_pkg::WR_IDLE) && wr_xfer_data_vld;
    assign page_end   = wr_xfer_data_vld && (wr_batch == LAST_IDX || wr_end_of_packet);
    assign cur_page   = (wr_batch == '0) ? head_page : page_reg; // Fresh page on word 0
    assign pop        = wr_xfer_data_vld && (wr_batch == '0);
    assign peek_offset = hdr_accept ? // Queue already steps past the header page
        PAGE_ADDR_W'(wr_xfer_data[packet_pkg::HDR_LEN_LSB +: packet_pkg::LEN_W]) - 1'b1 : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_state <= packet_pkg::WR_IDLE;
        end else if (wr_xfer_data_vld) begin
            case (wr_state)
                packet_pkg::WR_IDLE:
                    if (!wr_end_of_packet) wr_state <= packet_pkg::WR_FIRST_PAGE;
                packet_pkg::WR_FIRST_PAGE:
                    if (wr_end_of_packet) wr_state <= packet_pkg::WR_IDLE;
                    else if (wr_batch == LAST_IDX) wr_state <= packet_pkg::WR_LATER_PAGES;
                default:
                    if (wr_end_of_packet) wr_state <= packet_pkg::WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_batch <= '0;
        end else if (wr_xfer_data_vld) begin
            wr_batch <= wr_end_of_packet ? '0 : wr_batch + 1'b1; // Wraps at page end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            page_reg <= head_page;
        end
    end

    // Chain every non-tail page; the last word's link is the one kept
    assign tail_page    = join_request_enable ? head_page : join_request_tail[PAGE_ADDR_W-1:0];
    assign link_wr_vld  = wr_xfer_data_vld && (cur_page != tail_page);
    assign link_page    = cur_page;
    assign link_next    = {sram_idx, head_page};

    //////////////////////////////////////////////////////////////
    // Check code
    //////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_xfer_data_vld) begin
            if (wr_batch == '0) begin
                for (int i = 0; i < buffer_geom_pkg::WORDS_PER_PAGE; i++) begin
                    stage[i] <= '0; // Short last page pads with zeros
                end
            end
            stage[wr_batch] <= wr_xfer_data;
        end
    end

    ecc_encoder ecc_encoder_i (
        .word_0(stage[0]), .word_1(stage[1]), .word_2(stage[2]), .word_3(stage[3]),
        .word_4(stage[4]), .word_5(stage[5]), .word_6(stage[6]), .word_7(stage[7]),
        .code  (code)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            code_wr_pend <= 1'b0;
        end else begin
            code_wr_pend <= page_end; // Staging complete one cycle later
        end
    end

    always_ff @(posedge clk) begin
        if (page_end) code_wr_page <= cur_page;
        if (code_wr_pend) code_mem[code_wr_page] <= code;
        if (rd_page_down) rd_ecc_code <= code_mem[rd_page];
    end

    //////////////////////////////////////////////////////////////
    // Join request
    //////////////////////////////////////////////////////////////

    assign ts_next = time_stamp + 1'b1;

    always_ff @(posedge clk) begin
        if (hdr_accept) begin
            join_request_dest_port <= wr_xfer_data[packet_pkg::HDR_PORT_LSB +: packet_pkg::PORT_W];
            join_request_prior     <= wr_xfer_data[packet_pkg::HDR_PRIOR_LSB +: packet_pkg::PRIOR_W];
            join_request_head      <= {sram_idx, cur_page};
            packet_pages <= wr_xfer_data[packet_pkg::HDR_LEN_LSB +: packet_pkg::LEN_W] + 1'b1;
        end
        if (join_request_enable) begin
            join_request_tail <= {sram_idx, head_page}; // Peeked tail arrives now
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            join_request_enable     <= 1'b0;
            join_request_time_stamp <= packet_pkg::TS_IDLE;
        end else begin
            join_request_enable <= hdr_accept;
            if (hdr_accept) begin
                join_request_time_stamp <= {1'b0, ts_next};
            end else if ({1'b0, ts_next} == join_request_time_stamp) begin
                join_request_time_stamp <= packet_pkg::TS_IDLE; // Full wrap, drop the stamp
            end
        end
    end

    //////////////////////////////////////////////////////////////
    // Read side and free count
    //////////////////////////////////////////////////////////////

    assign rd_word      = rd_page_down ? '0 : rd_batch[IDX_W-1:0];
    assign recycle_vld  = rd_page_down;  // Page read out returns to the queue
    assign recycle_page = rd_page;
    assign link_rd_page = rd_page;
    assign rd_next_page = link_rd_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_batch         <= RD_IDLE;
            rd_xfer_data_vld <= 1'b0;
        end else begin
            rd_xfer_data_vld <= rd_page_down || (rd_batch != RD_IDLE);
            if (rd_page_down) begin
                rd_batch <= 4'd1; // Word 0 issued this cycle
            end else if (rd_batch != RD_IDLE) begin
                rd_batch <= rd_batch + 1'b1;
            end
        end
    end

    sram #(
        .PAGE_ADDR_W(PAGE_ADDR_W)
    ) sram_i (
        .clk    (clk),
        .wr_en  (wr_xfer_data_vld),
        .wr_addr({cur_page, wr_batch}),
        .din    (wr_xfer_data),
        .rd_en  (rd_page_down || (rd_batch != RD_IDLE)),
        .rd_addr({rd_page, rd_word}),
        .dout   (rd_xfer_data)
    );

    assign join_pages = join_request_enable ? PAGE_ADDR_W'(packet_pages) : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            free_space <= '1;
        end else begin
            free_space <= free_space - join_pages + PAGE_ADDR_W'(rd_page_down);
        end
    end

endmodule
